/* source/coherence_pkg.sv */
/*
 * Coherence package
 * Shared geometry of the L1 data cache, the MESI line state
 * and the block type used both as one value and as bus words
 */
package coherence_pkg;

    // Data path geometry
    localparam int word_w          = 32;
    localparam int words_per_block = 2;
    localparam int block_w         = word_w * words_per_block;
    localparam int bytes_per_word  = word_w / 8;

    // Cache geometry, direct mapped
    localparam int num_lines = 8;
    localparam int index_w   = 3;
    localparam int tag_w     = 26;

    // Address split: tag | index | word | byte
    localparam int word_bit  = 2;               // Selects the word in a block
    localparam int index_lsb = word_bit + 1;    // Bits 5 to 3
    localparam int tag_lsb   = index_lsb + index_w; // Bits 31 to 6

    // MESI line state
    typedef enum logic [1:0] {
        invalid   = 2'b00,
        shared    = 2'b01,
        exclusive = 2'b10,
        modified  = 2'b11
    } mesi_t;

    // One cache block
    // raw is the whole block, words[n] is bus beat n
    typedef union packed {
        logic [block_w-1:0]                     raw;
        logic [words_per_block-1:0][word_w-1:0] words;
    } cache_block_u;

endpackage

/* source/cache_tag_array.sv */
/*
 * Cache tag array
 * Holds tag and MESI state per line, looks up the processor
 * and snoop addresses and reports the victim at the processor index
 */
module cache_tag_array (
    input  logic                            CLK,
    input  logic                            rst,
    input  logic [31:0]                     proc_addr,
    input  logic [31:0]                     snoop_addr,
    output coherence_pkg::mesi_t            proc_state,
    output coherence_pkg::mesi_t            snoop_state,
    output logic [coherence_pkg::tag_w-1:0] victim_tag,
    output coherence_pkg::mesi_t            victim_state,
    input  logic                            update_en,
    input  logic [coherence_pkg::index_w-1:0] update_index,
    input  logic [coherence_pkg::tag_w-1:0] update_tag,
    input  coherence_pkg::mesi_t            update_state
);
    import coherence_pkg::*;

    logic [tag_w-1:0] tags [num_lines];   // Tag storage
    mesi_t            states [num_lines]; // Line states

    logic [index_w-1:0] proc_index;
    logic [index_w-1:0] snoop_index;
    logic [tag_w-1:0]   proc_tag;
    logic [tag_w-1:0]   snoop_tag;

    assign proc_index  = proc_addr[index_lsb +: index_w];
    assign snoop_index = snoop_addr[index_lsb +: index_w];
    assign proc_tag    = proc_addr[tag_lsb +: tag_w];
    assign snoop_tag   = snoop_addr[tag_lsb +: tag_w];

    // States are control, all lines invalid out of reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < num_lines; i++) begin
                states[i] <= invalid;
            end
        end else if (update_en) begin
            states[update_index] <= update_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (update_en) tags[update_index] <= update_tag; // Tag follows the state write
    end

    // Lookups read straight from the registers
    assign proc_state  = (tags[proc_index] == proc_tag) ? states[proc_index] : invalid;
    assign snoop_state = (tags[snoop_index] == snoop_tag) ? states[snoop_index] : invalid;

    // Resident line at the processor index, candidate for eviction
    assign victim_tag   = tags[proc_index];
    assign victim_state = states[proc_index];

endmodule

/* source/cache_data_array.sv */
/*
 * Cache data array
 * Block storage with a byte-enabled processor write and word-wise fill
 */
module cache_data_array (
    input  logic                        CLK,
    input  logic [31:0]                 proc_addr,
    input  logic [31:0]                 snoop_addr,
    output coherence_pkg::cache_block_u proc_block,
    output coherence_pkg::cache_block_u snoop_block,
    input  logic                        cpu_wen,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  byte_en,
    input  logic                        fill_en,
    input  logic                        fill_word,
    input  logic [31:0]                 fill_data
);
    import coherence_pkg::*;

    cache_block_u blocks [num_lines];

    logic [index_w-1:0] proc_index;
    logic [block_w-1:0] byte_mask;  // Bits touched by a processor write
    logic [block_w-1:0] wdata_wide; // Write word copied into every slot

    assign proc_index = proc_addr[index_lsb +: index_w];

    // Expand byte enables into a bit mask over the whole block
    always_comb begin
        byte_mask = '0;
        for (int b = 0; b < bytes_per_word; b++) begin
            byte_mask[proc_addr[word_bit]*word_w + 8*b +: 8] = {8{byte_en[b]}};
        end
        wdata_wide = {words_per_block{wdata}};
    end

    always_ff @(posedge CLK) begin
        if (fill_en) begin
            blocks[proc_index].words[fill_word] <= fill_data; // One bus beat
        end else if (cpu_wen) begin
            blocks[proc_index].raw <= (blocks[proc_index].raw & ~byte_mask)
                                    | (wdata_wide & byte_mask);
        end
    end

    assign proc_block  = blocks[proc_index];
    assign snoop_block = blocks[snoop_addr[index_lsb +: index_w]]; // Tag checked elsewhere

endmodule

/* source/beat_counter.sv */
/*
 * Beat counter
 * Counts word beats of one block transfer, flags the final beat
 */
module beat_counter (
    input  logic CLK,
    input  logic rst,
    input  logic clear,
    input  logic advance,
    output logic beat,
    output logic last
);
    import coherence_pkg::*;

    localparam logic last_beat = 1'(words_per_block - 1);

    always_ff @(posedge CLK) begin
        if (rst) begin
            beat <= 1'b0;
        end else if (clear) begin
            beat <= 1'b0;
        end else if (advance) begin
            beat <= last ? 1'b0 : beat + 1'b1; // Wrap after the final word
        end
    end

    assign last = (beat == last_beat);

endmodule

/* source/coherence_fsm.sv */
/*
 * Coherence controller
 * Serves processor hits and misses, writebacks, read-exclusive
 * upgrades and snoop responses for the MESI L1 cache
 */
module coherence_fsm (
    input  logic                            CLK,
    input  logic                            rst,
    input  logic                            ren,
    input  logic                            wen,
    input  logic [31:0]                     addr,
    output logic                            busy,
    input  coherence_pkg::mesi_t            proc_state,
    input  coherence_pkg::mesi_t            snoop_state,
    input  coherence_pkg::mesi_t            victim_state,
    input  logic [coherence_pkg::tag_w-1:0] victim_tag,
    input  logic                            dwait,
    input  logic                            ccexclusive,
    output logic                            dREN,
    output logic                            dWEN,
    output logic                            ccwrite,
    output logic [31:0]                     daddr,
    input  logic                            ccwait,
    input  logic                            ccinv,
    input  logic [31:0]                     ccsnoopaddr,
    output logic                            ccsnoophit,
    output logic                            ccdirty,
    output logic                            ccsnoopdone,
    output logic                            update_en,
    output logic [coherence_pkg::tag_w-1:0] update_tag,
    output coherence_pkg::mesi_t            update_state,
    output logic                            cpu_wen,
    output logic                            fill_en,
    output logic                            beat_clear,
    output logic                            beat_advance,
    input  logic                            beat,
    input  logic                            last,
    output logic                            wb_select
);
    import coherence_pkg::*;

    typedef enum logic [2:0] {
        idle,
        writeback,
        fill,
        complete,
        snoop_reply,
        supply
    } state_t;

    state_t state;
    state_t next_state;

    logic [index_w-1:0] proc_index;
    logic [tag_w-1:0]   proc_tag;
    logic               proc_hit;
    logic               write_ok;

    assign proc_index = addr[index_lsb +: index_w];
    assign proc_tag   = addr[tag_lsb +: tag_w];
    assign proc_hit   = (proc_state != invalid);
    assign write_ok   = (proc_state == exclusive) || (proc_state == modified); // No bus needed

    always_ff @(posedge CLK) begin
        if (rst) state <= idle;
        else     state <= next_state;
    end

    always_comb begin
        next_state   = state;
        busy         = ren || wen;     // Low only when a request completes
        dREN         = 1'b0;
        dWEN         = 1'b0;
        ccwrite      = 1'b0;
        daddr        = {proc_tag, proc_index, beat, {word_bit{1'b0}}};
        ccsnoophit   = 1'b0;
        ccdirty      = 1'b0;
        ccsnoopdone  = 1'b0;
        update_en    = 1'b0;
        update_tag   = proc_tag;
        update_state = modified;
        cpu_wen      = 1'b0;
        fill_en      = 1'b0;
        beat_clear   = 1'b0;
        beat_advance = 1'b0;
        wb_select    = 1'b0;

        case (state)
            idle: begin
                beat_clear = 1'b1;
                if (ccwait) begin
                    next_state = snoop_reply; // Snoop wins over the processor
                end else if (ren && proc_hit) begin
                    busy = 1'b0;
                end else if (wen && write_ok) begin
                    busy      = 1'b0;
                    cpu_wen   = 1'b1;
                    update_en = 1'b1; // E or M becomes M
                end else if (ren || wen) begin
                    // Miss or write to Shared, evict a dirty victim first
                    next_state = (victim_state == modified) ? writeback : fill;
                end
            end

            writeback: begin
                dWEN         = 1'b1;
                daddr        = {victim_tag, proc_index, beat, {word_bit{1'b0}}};
                beat_advance = !dwait;
                if (!dwait && last) next_state = fill;
            end

            fill: begin
                dREN         = 1'b1;
                ccwrite      = wen;     // Read-exclusive for a write
                fill_en      = !dwait;
                beat_advance = !dwait;
                if (!dwait && last) begin
                    update_en = 1'b1;
                    if (wen)              update_state = modified;
                    else if (ccexclusive) update_state = exclusive;
                    else                  update_state = shared;
                    next_state = complete;
                end
            end

            complete: begin
                busy       = 1'b0;
                cpu_wen    = wen; // Merge the write into the new line
                next_state = idle;
            end

            snoop_reply: begin
                wb_select    = 1'b1;
                ccsnoopdone  = 1'b1; // One-cycle pulse
                ccsnoophit   = (snoop_state != invalid);
                ccdirty      = (snoop_state == modified);
                update_tag   = ccsnoopaddr[tag_lsb +: tag_w];
                update_state = ccinv ? invalid : shared;
                if (snoop_state == modified) begin
                    next_state = supply;
                end else begin
                    update_en  = (snoop_state != invalid);
                    next_state = idle;
                end
            end

            supply: begin
                // Dirty block goes out on dstore, state drops after the last beat
                wb_select    = 1'b1;
                ccsnoophit   = 1'b1;
                ccdirty      = 1'b1;
                beat_advance = !dwait;
                update_tag   = ccsnoopaddr[tag_lsb +: tag_w];
                update_state = ccinv ? invalid : shared;
                if (!dwait && last) begin
                    update_en  = 1'b1;
                    next_state = idle;
                end
            end

            default: next_state = idle;
        endcase
    end

endmodule

/* source/l1_coherent_cache.sv */
/*
 * Coherent L1 data cache
 * Direct-mapped MESI cache between the processor port and the snooping bus
 */
module l1_coherent_cache (
    input  logic        CLK,
    input  logic        rst,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  byte_en,
    output logic [31:0] rdata,
    output logic        busy,
    output logic        dREN,
    output logic        dWEN,
    output logic        ccwrite,
    output logic [31:0] daddr,
    output logic [31:0] dstore,
    input  logic [31:0] dload,
    input  logic        dwait,
    input  logic        ccexclusive,
    input  logic        ccwait,
    input  logic        ccinv,
    input  logic [31:0] ccsnoopaddr,
    output logic        ccsnoophit,
    output logic        ccdirty,
    output logic        ccsnoopdone
);
    import coherence_pkg::*;

    mesi_t              proc_state, snoop_state, victim_state;
    logic [tag_w-1:0]   victim_tag;
    logic               update_en;
    logic [index_w-1:0] update_index;
    logic [tag_w-1:0]   update_tag;
    mesi_t              update_state;
    logic               cpu_wen, fill_en;
    logic               beat_clear, beat_advance;
    logic               beat, last;
    logic               wb_select;      // High while serving a snoop
    cache_block_u       proc_block, snoop_block;

    // Snoop updates go to the snooped line, all others to the processor line
    assign update_index = wb_select ? ccsnoopaddr[index_lsb +: index_w]
                                    : addr[index_lsb +: index_w];

    assign rdata  = proc_block.words[addr[word_bit]];
    assign dstore = wb_select ? snoop_block.words[beat] : proc_block.words[beat];

    cache_tag_array tags (
        .CLK, .rst,
        .proc_addr(addr), .snoop_addr(ccsnoopaddr),
        .proc_state, .snoop_state, .victim_tag, .victim_state,
        .update_en, .update_index, .update_tag, .update_state
    );

    cache_data_array data (
        .CLK,
        .proc_addr(addr), .snoop_addr(ccsnoopaddr),
        .proc_block, .snoop_block,
        .cpu_wen, .wdata, .byte_en,
        .fill_en, .fill_word(beat), .fill_data(dload)
    );

    beat_counter beats (
        .CLK, .rst,
        .clear(beat_clear), .advance(beat_advance),
        .beat, .last
    );

    coherence_fsm ctrl (
        .CLK, .rst,
        .ren, .wen, .addr, .busy,
        .proc_state, .snoop_state, .victim_state, .victim_tag,
        .dwait, .ccexclusive, .dREN, .dWEN, .ccwrite, .daddr,
        .ccwait, .ccinv, .ccsnoopaddr, .ccsnoophit, .ccdirty, .ccsnoopdone,
        .update_en, .update_tag, .update_state, .cpu_wen, .fill_en,
        .beat_clear, .beat_advance, .beat, .last,
        .wb_select
    );

endmodule

/* sim/tb_cache_coherency.sv */
/*
 * Testbench for the coherent L1 data cache
 * Models the bus, the L2 and the other caches, checks MESI behavior with assertions
 */
module tb_cache_coherency;
    timeunit 1ns;
    timeprecision 100ps;
    import coherence_pkg::*;

    localparam int beat_cycles  = 8;   // Worst stall per beat
    localparam int num_requests = 25;
    localparam int num_snoops   = 10;
    localparam int cycle_limit  = 20 * (num_requests * (4 * beat_cycles + 2)
                                        + num_snoops * (2 * beat_cycles + 2)) + 16;

    logic        CLK = 1'b0;
    logic        rst, ren, wen, ccexclusive, ccwait, ccinv;
    logic [31:0] addr, wdata, ccsnoopaddr;
    logic [3:0]  byte_en;
    logic        dwait = 1'b1;
    logic [31:0] dload = '0;
    logic [31:0] rdata, daddr, dstore;
    logic        busy, dREN, dWEN, ccwrite, ccsnoophit, ccdirty, ccsnoopdone;

    logic [31:0] l2 [128];        // L2 words by address bits 8:2
    logic [31:0] exp_mem [128];   // Latest coherent value of each word
    mesi_t       exp_state [64];  // Expected line state by address bits 8:3
    logic [31:0] load_addr = '0;  // Word that dload holds
    logic        exp_fast, exp_ccwrite, exp_wb;
    logic [5:0]  exp_line;        // Block the fill must address
    logic [5:0]  exp_victim;      // Block the writeback must address
    int          wb_beats, errors, errors_seen, test_num, cycles;
    logic        xfer;
    logic [31:0] exp_rdata, wb_exp;
    mesi_t       snoop_exp;

    assign xfer      = dREN || dWEN || (ccwait && ccdirty && !ccsnoopdone); // Beats in flight
    assign exp_rdata = exp_mem[addr[8:2]];
    assign wb_exp    = exp_mem[daddr[8:2]];
    assign snoop_exp = exp_state[ccsnoopaddr[8:3]];

    l1_coherent_cache uut (.*);

    always #20 CLK = ~CLK;

    // Bus and L2 model, a beat is released only once dload matches daddr
    always @(posedge CLK) begin
        if (rst) begin
            dwait <= 1'b1;
        end else if (xfer) begin
            if (dWEN && !dwait) begin
                l2[daddr[8:2]] = dstore; // Writeback beat
                wb_beats++;
            end
            if (!dwait) dwait <= 1'b1;  // Beat consumed, next word loads first
            else if (daddr == load_addr && ($urandom % 4) != 0) dwait <= 1'b0;
            dload     <= l2[daddr[8:2]];
            load_addr <= daddr;
        end else begin
            dwait <= 1'b1;
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    reset_state: assert property (@(posedge CLK) $fell(rst) |->
            !dREN && !dWEN && !ccwrite && !ccsnoopdone && !busy)
        else begin errors++; $display("Control outputs not low after reset"); end
    first_cycle: assert property (@(posedge CLK) disable iff (rst)
            $rose(ren || wen) |-> busy == !exp_fast)
        else begin errors++; $display("MISMATCH busy expected %h got %h",
                                      !$sampled(exp_fast), $sampled(busy)); end
    read_data: assert property (@(posedge CLK) disable iff (rst) ren && !busy |-> rdata == exp_rdata)
        else begin errors++; $display("MISMATCH rdata expected %h got %h",
                                      $sampled(exp_rdata), $sampled(rdata)); end
    no_bus_on_hit: assert property (@(posedge CLK) disable iff (rst) dREN || dWEN |-> !exp_fast)
        else begin errors++; $display("Bus request issued for a cache hit"); end
    bus_addr: assert property (@(posedge CLK) disable iff (rst) dREN || dWEN |->
            daddr[31:9] == '0 && daddr[8:3] == (dWEN ? exp_victim : exp_line))
        else begin errors++; $display("MISMATCH daddr block expected %h got %h",
                                      $sampled(dWEN) ? $sampled(exp_victim) : $sampled(exp_line),
                                      $sampled(daddr[31:3])); end
    fill_kind: assert property (@(posedge CLK) disable iff (rst) $rose(dREN) |-> ccwrite == exp_ccwrite)
        else begin errors++; $display("MISMATCH ccwrite expected %h got %h",
                                      $sampled(exp_ccwrite), $sampled(ccwrite)); end
    evict_first: assert property (@(posedge CLK) disable iff (rst)
            $rose(dREN) |-> wb_beats == (exp_wb ? 2 : 0))
        else begin errors++; $display("MISMATCH writeback beats expected %h got %h",
                                      $sampled(exp_wb) ? 2 : 0, $sampled(wb_beats)); end
    wb_data: assert property (@(posedge CLK) disable iff (rst) dWEN && !dwait |-> dstore == wb_exp)
        else begin errors++; $display("MISMATCH dstore expected %h got %h",
                                      $sampled(wb_exp), $sampled(dstore)); end
    stall_hold: assert property (@(posedge CLK) disable iff (rst) xfer && dwait |=>
            $stable(daddr) && $stable(dstore) && $stable(dREN) && $stable(dWEN) && $stable(ccwrite))
        else begin errors++; $display("Bus outputs changed while dwait was high"); end
    snoop_timing: assert property (@(posedge CLK) disable iff (rst)
            $rose(ccwait) |-> !ccsnoopdone ##1 ccsnoopdone ##1 !ccsnoopdone)
        else begin errors++; $display("ccsnoopdone was not a pulse one cycle after the snoop"); end
    snoop_hit: assert property (@(posedge CLK) disable iff (rst)
            ccsnoopdone |-> ccsnoophit == (snoop_exp != invalid))
        else begin errors++; $display("MISMATCH ccsnoophit expected %h got %h",
                                      $sampled(snoop_exp) != invalid, $sampled(ccsnoophit)); end
    snoop_dirty: assert property (@(posedge CLK) disable iff (rst)
            ccsnoopdone |-> ccdirty == (snoop_exp == modified))
        else begin errors++; $display("MISMATCH ccdirty expected %h got %h",
                                      $sampled(snoop_exp) == modified, $sampled(ccdirty)); end

    // One processor request, held until busy drops, then the model follows the MESI rules
    task automatic access(input logic wr, input logic [31:0] a, input logic [31:0] data,
                          input logic [3:0] be, input logic excl);
        mesi_t st;
        @(posedge CLK);
        st          = exp_state[a[8:3]];
        exp_fast    = wr ? (st == exclusive || st == modified) : (st != invalid);
        exp_ccwrite = wr;
        exp_wb      = 1'b0;
        exp_line    = a[8:3];
        exp_victim  = a[8:3];
        wb_beats    = 0;
        for (int t = 0; t < 8; t++) begin
            if (t != a[8:6] && exp_state[{t[2:0], a[5:3]}] == modified) begin
                exp_wb     = 1'b1;
                exp_victim = {t[2:0], a[5:3]};
            end
        end
        ren         <= !wr;
        wen         <= wr;
        addr        <= a;
        wdata       <= data;
        byte_en     <= be;
        ccexclusive <= excl;
        do @(posedge CLK); while (busy);
        ren <= 1'b0;
        wen <= 1'b0;
        if (!exp_fast) begin
            for (int t = 0; t < 8; t++) exp_state[{t[2:0], a[5:3]}] = invalid; // Evicted
            exp_state[a[8:3]] = excl ? exclusive : shared;
        end
        if (wr) begin
            exp_state[a[8:3]] = modified;
            for (int b = 0; b < 4; b++) begin
                if (be[b]) exp_mem[a[8:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
        exp_fast = 1'b0;
    endtask

    // Snoop from another cache, collects a dirty block as it is supplied
    task automatic snoop(input logic [31:0] a, input logic inv);
        mesi_t st;
        logic  bw;
        @(posedge CLK);
        st          = exp_state[a[8:3]];
        bw          = 1'b0;
        ccwait      <= 1'b1;
        ccsnoopaddr <= a;
        ccinv       <= inv;
        do @(posedge CLK); while (!ccsnoopdone);
        if (ccdirty) begin
            do begin
                @(posedge CLK);
                if (!dwait) begin
                    assert (dstore == exp_mem[{a[8:3], bw}])
                        else begin
                            errors++;
                            $display("MISMATCH dstore expected %h got %h",
                                     exp_mem[{a[8:3], bw}], dstore);
                        end
                    l2[{a[8:3], bw}] = dstore; // Block goes back to memory
                    bw = !bw;
                    if (!bw) break;
                end
            end while (1'b1);
        end
        ccwait <= 1'b0;
        if (st != invalid) exp_state[a[8:3]] = inv ? invalid : shared;
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("Test %0d %s: %0d failed checks", test_num, name, errors - errors_seen);
        errors_seen = errors;
    endtask

    initial begin
        logic [31:0] a;
        void'($urandom(32'h671486c1));
        rst = 1'b1;
        {ren, wen, ccexclusive, ccwait, ccinv} = '0;
        {addr, wdata, ccsnoopaddr} = '0;
        byte_en = 4'h0;
        {errors, errors_seen, test_num, cycles, wb_beats} = '0;
        {exp_fast, exp_ccwrite, exp_wb} = '0;
        exp_line   = '0;
        exp_victim = '0;
        for (int i = 0; i < 128; i++) begin
            l2[i]      = 32'h9e3779b9 * (i + 1); // Differs for every word address
            exp_mem[i] = l2[i];
        end
        for (int i = 0; i < 64; i++) exp_state[i] = invalid;
        repeat (16) @(posedge CLK);
        rst <= 1'b0;

        access(0, 32'h08, 0, 4'h0, 1);            // I to E
        access(1, 32'h0c, 32'hcafe0001, 4'hf, 1); // E to M on a hit
        snoop(32'h08, 0);
        end_test("read miss exclusive, write hit, dirty snoop");

        access(0, 32'h10, 0, 4'h0, 0);            // Installed Shared
        access(1, 32'h10, 32'h12345678, 4'h3, 0); // Upgrade by read-exclusive
        snoop(32'h10, 0);
        end_test("shared fill and upgrade");

        access(0, 32'h18, 0, 4'h0, 1);
        access(1, 32'h18, 32'haabbccdd, 4'hc, 0);
        access(1, 32'h1c, 32'h0badf00d, 4'hf, 0);
        snoop(32'h18, 0);                          // M to S, merged block supplied
        snoop(32'h18, 0);
        access(1, 32'h18, 32'h000000ee, 4'h1, 0);
        access(0, 32'h1c, 0, 4'h0, 0);
        end_test("snoop without invalidate");

        access(0, 32'h48, 0, 4'h0, 1);            // Displaces a clean line
        snoop(32'h48, 1);                          // E to I
        snoop(32'h48, 0);
        access(0, 32'h48, 0, 4'h0, 0);
        snoop(32'h10, 1);                          // S to I
        snoop(32'h10, 0);
        end_test("snoop invalidate");

        access(0, 32'h58, 0, 4'h0, 1);            // Modified victim written back
        access(0, 32'h18, 0, 4'h0, 0);
        end_test("dirty eviction");

        for (int i = 0; i < 6; i++) begin
            a = i[0] ? 32'h68 : 32'h28;
            access(1, a, $urandom, 4'hf, 0);
            if (i % 3 == 2) snoop(a, i[0]);
            access(0, a ^ 32'h40, 0, 4'h0, i[1]);  // Other tag, same index
        end
        end_test("random stalls and conflicts");

        $display("Tests run: %0d, failed checks: %0d", test_num, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* flist.f */
source/coherence_pkg.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/beat_counter.sv
source/coherence_fsm.sv
source/l1_coherent_cache.sv
sim/tb_cache_coherency.sv
